/* rtl/rf_settings.svh */
// Register file and write-back settings
// Widths, FP bank enable and skid buffer depth shared by the RTL

`ifndef RF_SETTINGS_SVH
`define RF_SETTINGS_SVH

// --------------------
// Register file shape
// --------------------

// FP bank present when nonzero
`define RF_HAS_FP 1

// Extra address bit selects the FP bank
`define RF_ADDR_WIDTH ((`RF_HAS_FP != 0) ? 6 : 5)

// Width of one register
`define RF_DATA_WIDTH 32

// --------------------
// Write-back lanes
// --------------------

// Output register plus one spill entry
`define WB_SKID_DEPTH 2

`endif

/* rtl/rf_pkg.sv */
// Register file types
// Address, data and bank index, plus the bank decode helper

`include "rf_settings.svh"

package rf_pkg;

  // Index bits inside one bank
  localparam int unsigned RF_IDX_WIDTH = `RF_ADDR_WIDTH - `RF_HAS_FP;

  // Registers per bank, the same for INT and FP
  localparam int unsigned RF_BANK_WORDS = 2 ** RF_IDX_WIDTH;

  // Register address, top bit is the bank when FP exists
  typedef logic [`RF_ADDR_WIDTH-1:0] reg_addr_t;

  // One register word
  typedef logic [`RF_DATA_WIDTH-1:0] reg_data_t;

  // Bank index
  typedef enum logic {
    INT = 1'b0,
    FP  = 1'b1
  } rf_bank_e;

  // Bank addressed by a register address
  // Always INT when the FP bank is left out
  function automatic rf_bank_e rf_bank_of(input reg_addr_t addr);
    return ((`RF_HAS_FP != 0) && addr[`RF_ADDR_WIDTH-1]) ? FP : INT;
  endfunction

endpackage

/* rtl/wb_pkg.sv */
// Write-back payload types
// Payloads carried by the ALU and load lanes through their skid buffers

package wb_pkg;

  import rf_pkg::*;

  // --------------------
  // Load access size
  // --------------------

  typedef enum logic [1:0] {
    BYTE = 2'b00,
    HALF = 2'b01,
    WORD = 2'b10
  } load_size_e;

  // --------------------
  // Lane payloads
  // --------------------

  // ALU result, already final
  typedef struct packed {
    reg_addr_t addr;
    reg_data_t data;
  } alu_wb_t;

  // Raw load word, formatted after the skid buffer
  typedef struct packed {
    reg_addr_t  addr;
    // Whole aligned memory word
    reg_data_t  raw;
    // Byte offset of the access inside the word
    logic [1:0] offset;
    load_size_e size;
    // Sign extend when set
    logic       is_signed;
  } lsu_wb_t;

endpackage

/* rtl/wb_skid_buffer.sv */
// Write-back skid buffer
// Registered output stage plus one spill entry, any packed payload
// in_ready_o is registered and never follows out_ready_i in the same cycle

`timescale 1ns/1ps

`include "rf_settings.svh"

module wb_skid_buffer #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
);

  localparam int unsigned Depth = `WB_SKID_DEPTH;
  localparam int unsigned FillW = $clog2(Depth + 1);

  payload_t         out_data_q;
  payload_t         spill_data_q;
  logic             out_valid_q;
  logic             out_valid_d;
  logic             spill_valid_q;
  logic             spill_valid_d;
  logic             in_ready_q;
  logic [FillW-1:0] fill_q;
  logic [FillW-1:0] fill_d;
  logic             accept;
  logic             pop;

  assign accept = in_valid_i & in_ready_q;
  assign pop    = out_valid_q & out_ready_i;

  // --------------------
  // Occupancy
  // --------------------

  always_comb begin
    out_valid_d   = out_valid_q;
    spill_valid_d = spill_valid_q;
    if (pop || !out_valid_q) begin
      // Output slot frees up, spill entry drains first to keep order
      out_valid_d   = spill_valid_q | accept;
      spill_valid_d = 1'b0;
    end else if (accept) begin
      // Output held, park the new item
      spill_valid_d = 1'b1;
    end
  end

  assign fill_q = FillW'(out_valid_q) + FillW'(spill_valid_q);
  assign fill_d = FillW'(out_valid_d) + FillW'(spill_valid_d);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid_q   <= 1'b0;
      spill_valid_q <= 1'b0;
      in_ready_q    <= 1'b1;
    end else begin
      out_valid_q   <= out_valid_d;
      spill_valid_q <= spill_valid_d;
      // Ready drops only once both entries hold data
      in_ready_q    <= (fill_d < Depth);
    end
  end

  // --------------------
  // Payload
  // --------------------

  always_ff @(posedge clk) begin
    if (pop || !out_valid_q) begin
      if (spill_valid_q) begin
        out_data_q <= spill_data_q;
      end else if (accept) begin
        out_data_q <= in_data_i;
      end
    end else if (accept) begin
      spill_data_q <= in_data_i;
    end
  end

  assign in_ready_o  = in_ready_q;
  assign out_valid_o = out_valid_q;
  assign out_data_o  = out_data_q;

  // Stalled output keeps its item
  a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o));

  // Full buffer takes nothing in
  a_no_overfill: assert property (@(posedge clk) disable iff (!rst_n)
    (fill_q == Depth) |-> !(in_valid_i && in_ready_o));

endmodule

/* rtl/load_formatter.sv */
// Load data formatter
// Picks byte, halfword or word from the raw load word and extends it

`timescale 1ns/1ps

`include "rf_settings.svh"

module load_formatter
  import rf_pkg::*;
  import wb_pkg::*;
(
  input  reg_data_t  raw_i,
  input  logic [1:0] offset_i,
  input  load_size_e size_i,
  input  logic       signed_i,
  output reg_data_t  data_o
);

  logic [7:0]  byte_sel;
  logic [15:0] half_sel;
  logic        byte_ext;
  logic        half_ext;

  // --------------------
  // Lane select
  // --------------------

  // Byte lane straight from the offset
  assign byte_sel = raw_i[{offset_i, 3'b000} +: 8];

  // Halfword from offset bit 1, bit 0 ignored
  assign half_sel = offset_i[1] ? raw_i[31:16] : raw_i[15:0];

  // --------------------
  // Extension
  // --------------------

  // Fill bit, zero for unsigned loads
  assign byte_ext = signed_i & byte_sel[7];
  assign half_ext = signed_i & half_sel[15];

  always_comb begin
    case (size_i)
      BYTE: begin
        data_o = {{(`RF_DATA_WIDTH-8){byte_ext}}, byte_sel};
      end
      HALF: begin
        data_o = {{(`RF_DATA_WIDTH-16){half_ext}}, half_sel};
      end
      default: begin
        // WORD and the unused code pass the raw word
        data_o = raw_i;
      end
    endcase
  end

endmodule

/* rtl/register_file.sv */
// Integer and FP register file
// Two write ports, port B has priority, port A stalls on a same-address clash
// Three combinational read ports, integer x0 hard-wired to zero

`timescale 1ns/1ps

`include "rf_settings.svh"

module register_file
  import rf_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  // Read ports
  input  reg_addr_t raddr_a_i,
  input  reg_addr_t raddr_b_i,
  input  reg_addr_t raddr_c_i,
  output reg_data_t rdata_a_o,
  output reg_data_t rdata_b_o,
  output reg_data_t rdata_c_o,
  // Write port A, ALU lane
  input  logic      wa_valid_i,
  output logic      wa_ready_o,
  input  reg_addr_t wa_addr_i,
  input  reg_data_t wa_data_i,
  // Write port B, load lane, never refused
  input  logic      wb_valid_i,
  input  reg_addr_t wb_addr_i,
  input  reg_data_t wb_data_i
);

  reg_data_t                int_q [RF_BANK_WORDS];
  reg_addr_t                raddr [3];
  reg_data_t                rdata [3];
  logic                     conflict;
  logic                     wa_fire;
  rf_bank_e                 wa_bank;
  rf_bank_e                 wb_bank;
  logic [RF_IDX_WIDTH-1:0]  wa_idx;
  logic [RF_IDX_WIDTH-1:0]  wb_idx;
  logic [RF_BANK_WORDS-1:0] wa_int_we;
  logic [RF_BANK_WORDS-1:0] wb_int_we;

  // --------------------
  // Write arbitration
  // --------------------

  // Same nonzero target on both ports, load goes first
  assign conflict   = wb_valid_i & (wa_addr_i == wb_addr_i) & (wa_addr_i != '0);
  assign wa_ready_o = ~conflict;
  assign wa_fire    = wa_valid_i & ~conflict;

  assign wa_bank = rf_bank_of(wa_addr_i);
  assign wb_bank = rf_bank_of(wb_addr_i);
  assign wa_idx  = wa_addr_i[RF_IDX_WIDTH-1:0];
  assign wb_idx  = wb_addr_i[RF_IDX_WIDTH-1:0];

  // Per-register enables for the integer bank
  always_comb begin
    wa_int_we = '0;
    wb_int_we = '0;
    if (wa_fire && wa_bank == INT) wa_int_we[wa_idx] = 1'b1;
    if (wb_valid_i && wb_bank == INT) wb_int_we[wb_idx] = 1'b1;
  end

  // Entry 0 never written, stays at its reset value
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      int_q <= '{default: '0};
    end else begin
      for (int i = 1; i < RF_BANK_WORDS; i++) begin
        if (wb_int_we[i]) begin
          int_q[i] <= wb_data_i;
        end else if (wa_int_we[i]) begin
          int_q[i] <= wa_data_i;
        end
      end
    end
  end

  // --------------------
  // Read ports
  // --------------------

  assign raddr[0]  = raddr_a_i;
  assign raddr[1]  = raddr_b_i;
  assign raddr[2]  = raddr_c_i;
  assign rdata_a_o = rdata[0];
  assign rdata_b_o = rdata[1];
  assign rdata_c_o = rdata[2];

  if (`RF_HAS_FP != 0) begin : gen_fp
    reg_data_t                fp_q [RF_BANK_WORDS];
    logic [RF_BANK_WORDS-1:0] wa_fp_we;
    logic [RF_BANK_WORDS-1:0] wb_fp_we;

    // FP bank has no hard-wired entry
    always_comb begin
      wa_fp_we = '0;
      wb_fp_we = '0;
      if (wa_fire && wa_bank == FP) wa_fp_we[wa_idx] = 1'b1;
      if (wb_valid_i && wb_bank == FP) wb_fp_we[wb_idx] = 1'b1;
    end

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        fp_q <= '{default: '0};
      end else begin
        for (int i = 0; i < RF_BANK_WORDS; i++) begin
          if (wb_fp_we[i]) begin
            fp_q[i] <= wb_data_i;
          end else if (wa_fp_we[i]) begin
            fp_q[i] <= wa_data_i;
          end
        end
      end
    end

    for (genvar p = 0; p < 3; p++) begin : gen_rd
      assign rdata[p] = (rf_bank_of(raddr[p]) == FP) ? fp_q[raddr[p][RF_IDX_WIDTH-1:0]]
                                                      : int_q[raddr[p][RF_IDX_WIDTH-1:0]];
    end
  end else begin : gen_int_only
    for (genvar p = 0; p < 3; p++) begin : gen_rd
      assign rdata[p] = int_q[raddr[p][RF_IDX_WIDTH-1:0]];
    end
  end

  // x0 reads zero on every port, whatever was written to it
  for (genvar p = 0; p < 3; p++) begin : gen_x0_chk
    a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
      (rf_bank_of(raddr[p]) == INT && raddr[p][RF_IDX_WIDTH-1:0] == '0) |-> rdata[p] == '0);
  end

endmodule

/* rtl/rf_writeback_top.sv */
// Write-back and operand-read top level
// ALU and load lanes through skid buffers into a two-port register file
// Load data is aligned and extended on its way to write port B

`timescale 1ns/1ps

module rf_writeback_top
  import rf_pkg::*;
  import wb_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  // ALU lane
  input  logic       alu_valid_i,
  output logic       alu_ready_o,
  input  reg_addr_t  alu_waddr_i,
  input  reg_data_t  alu_wdata_i,
  // Load lane
  input  logic       lsu_valid_i,
  output logic       lsu_ready_o,
  input  reg_addr_t  lsu_waddr_i,
  input  reg_data_t  lsu_rdata_i,
  input  logic [1:0] lsu_offset_i,
  input  load_size_e lsu_size_i,
  input  logic       lsu_signed_i,
  // Operand reads
  input  reg_addr_t  raddr_a_i,
  input  reg_addr_t  raddr_b_i,
  input  reg_addr_t  raddr_c_i,
  output reg_data_t  rdata_a_o,
  output reg_data_t  rdata_b_o,
  output reg_data_t  rdata_c_o
);

  alu_wb_t   alu_in;
  alu_wb_t   alu_out;
  logic      alu_out_valid;
  logic      alu_out_ready;
  lsu_wb_t   lsu_in;
  lsu_wb_t   lsu_out;
  logic      lsu_out_valid;
  reg_data_t lsu_wdata;

  // --------------------
  // ALU lane
  // --------------------

  assign alu_in.addr = alu_waddr_i;
  assign alu_in.data = alu_wdata_i;

  wb_skid_buffer #(
    .payload_t (alu_wb_t)
  ) i_alu_skid (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_i  (alu_valid_i),
    .in_ready_o  (alu_ready_o),
    .in_data_i   (alu_in),
    .out_valid_o (alu_out_valid),
    .out_ready_i (alu_out_ready),
    .out_data_o  (alu_out)
  );

  // --------------------
  // Load lane
  // --------------------

  assign lsu_in.addr      = lsu_waddr_i;
  assign lsu_in.raw       = lsu_rdata_i;
  assign lsu_in.offset    = lsu_offset_i;
  assign lsu_in.size      = lsu_size_i;
  assign lsu_in.is_signed = lsu_signed_i;

  // Port B never refuses, so the output side always drains
  wb_skid_buffer #(
    .payload_t (lsu_wb_t)
  ) i_lsu_skid (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_i  (lsu_valid_i),
    .in_ready_o  (lsu_ready_o),
    .in_data_i   (lsu_in),
    .out_valid_o (lsu_out_valid),
    .out_ready_i (1'b1),
    .out_data_o  (lsu_out)
  );

  load_formatter i_load_fmt (
    .raw_i    (lsu_out.raw),
    .offset_i (lsu_out.offset),
    .size_i   (lsu_out.size),
    .signed_i (lsu_out.is_signed),
    .data_o   (lsu_wdata)
  );

  // --------------------
  // Register file
  // --------------------

  register_file i_regfile (
    .clk        (clk),
    .rst_n      (rst_n),
    .raddr_a_i  (raddr_a_i),
    .raddr_b_i  (raddr_b_i),
    .raddr_c_i  (raddr_c_i),
    .rdata_a_o  (rdata_a_o),
    .rdata_b_o  (rdata_b_o),
    .rdata_c_o  (rdata_c_o),
    .wa_valid_i (alu_out_valid),
    .wa_ready_o (alu_out_ready),
    .wa_addr_i  (alu_out.addr),
    .wa_data_i  (alu_out.data),
    .wb_valid_i (lsu_out_valid),
    .wb_addr_i  (lsu_out.addr),
    .wb_data_i  (lsu_wdata)
  );

endmodule

/* tests/tb_rf_writeback_top.sv */
// Testbench for the write-back and operand-read top level
// Directed tests on both lanes, checked against a shadow register model

`timescale 1ns/1ps

`include "rf_settings.svh"

module tb_rf_writeback_top
  import rf_pkg::*;
  import wb_pkg::*;
();

  localparam int NumRegs = 2 ** `RF_ADDR_WIDTH;
  localparam int Timeout = 20;
  localparam int StreamLen = 16;

  logic       clk;
  logic       rst_n;
  logic       alu_valid;
  logic       alu_ready;
  reg_addr_t  alu_waddr;
  reg_data_t  alu_wdata;
  logic       lsu_valid;
  logic       lsu_ready;
  reg_addr_t  lsu_waddr;
  reg_data_t  lsu_rdata;
  logic [1:0] lsu_offset;
  load_size_e lsu_size;
  logic       lsu_signed;
  reg_addr_t  raddr_a;
  reg_addr_t  raddr_b;
  reg_addr_t  raddr_c;
  reg_data_t  rdata_a;
  reg_data_t  rdata_b;
  reg_data_t  rdata_c;

  // Shadow of every register, integer x0 included
  reg_data_t model [NumRegs];
  int        checks;
  int        errors;
  int        tests;
  int        chk_at_start;
  int        err_at_start;

  rf_writeback_top i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .alu_valid_i  (alu_valid),
    .alu_ready_o  (alu_ready),
    .alu_waddr_i  (alu_waddr),
    .alu_wdata_i  (alu_wdata),
    .lsu_valid_i  (lsu_valid),
    .lsu_ready_o  (lsu_ready),
    .lsu_waddr_i  (lsu_waddr),
    .lsu_rdata_i  (lsu_rdata),
    .lsu_offset_i (lsu_offset),
    .lsu_size_i   (lsu_size),
    .lsu_signed_i (lsu_signed),
    .raddr_a_i    (raddr_a),
    .raddr_b_i    (raddr_b),
    .raddr_c_i    (raddr_c),
    .rdata_a_o    (rdata_a),
    .rdata_b_o    (rdata_b),
    .rdata_c_o    (rdata_c)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // --------------------
  // Model and checks
  // --------------------

  // x0 of the integer bank never changes
  task automatic model_write(input reg_addr_t addr, input reg_data_t data);
    if (addr != '0) begin
      model[addr] = data;
    end
  endtask

  // Expected load result, built by shifting and masking
  function automatic reg_data_t expect_load(input reg_data_t raw, input logic [1:0] offset,
                                            input load_size_e size, input logic sgn);
    reg_data_t res;
    case (size)
      BYTE: begin
        res = (raw >> (8 * int'(offset))) & 32'h0000_00ff;
        if (sgn && res[7]) begin
          res = res | 32'hffff_ff00;
        end
      end
      HALF: begin
        res = (offset[1] ? (raw >> 16) : raw) & 32'h0000_ffff;
        if (sgn && res[15]) begin
          res = res | 32'hffff_0000;
        end
      end
      default: begin
        res = raw;
      end
    endcase
    return res;
  endfunction

  task automatic compare_value(input string what, input reg_data_t got, input reg_data_t exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[ERROR] %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  // Called on a falling edge, reads settle well before the next rising edge
  // Returns on the following falling edge
  task automatic check_reads(input reg_addr_t a, input reg_addr_t b, input reg_addr_t c);
    raddr_a = a;
    raddr_b = b;
    raddr_c = c;
    #10;
    compare_value($sformatf("read port a, reg %0d", a), rdata_a, model[a]);
    compare_value($sformatf("read port b, reg %0d", b), rdata_b, model[b]);
    compare_value($sformatf("read port c, reg %0d", c), rdata_c, model[c]);
    @(negedge clk);
  endtask

  task automatic abort_timeout(input string what);
    $display("Timeout after %0d cycles waiting for %s at %0t ns", Timeout, what, $time);
    $display("CHECKS FAILED");
    $finish;
  endtask

  // --------------------
  // Lane driving
  // --------------------

  task automatic drive_alu(input reg_addr_t addr, input reg_data_t data);
    alu_valid = 1'b1;
    alu_waddr = addr;
    alu_wdata = data;
  endtask

  task automatic drive_lsu(input reg_addr_t addr, input reg_data_t raw, input logic [1:0] off,
                           input load_size_e size, input logic sgn);
    lsu_valid  = 1'b1;
    lsu_waddr  = addr;
    lsu_rdata  = raw;
    lsu_offset = off;
    lsu_size   = size;
    lsu_signed = sgn;
  endtask

  // Ready is registered, so its value at the falling edge holds for the rising edge
  // Returns on the falling edge after the last acceptance
  task automatic complete_handshakes(input bit alu_pending, input bit lsu_pending);
    int  n;
    bit  alu_take;
    bit  lsu_take;
    n = 0;
    while ((alu_pending || lsu_pending) && n < Timeout) begin
      alu_take = alu_pending && alu_ready;
      lsu_take = lsu_pending && lsu_ready;
      @(posedge clk);
      @(negedge clk);
      if (alu_take) begin
        alu_valid   = 1'b0;
        alu_pending = 1'b0;
      end
      if (lsu_take) begin
        lsu_valid   = 1'b0;
        lsu_pending = 1'b0;
      end
      n++;
    end
    if (alu_pending || lsu_pending) begin
      abort_timeout("a lane handshake");
    end
  endtask

  task automatic settle(input int cycles);
    repeat (cycles) @(negedge clk);
  endtask

  task automatic begin_test();
    chk_at_start = checks;
    err_at_start = errors;
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("Test %-18s %0d checks, %0d errors", name, checks - chk_at_start,
             errors - err_at_start);
  endtask

  // --------------------
  // Directed tests
  // --------------------

  task automatic test_reset_x0();
    begin_test();
    compare_value("alu_ready_o after reset", reg_data_t'(alu_ready), 32'd1);
    compare_value("lsu_ready_o after reset", reg_data_t'(lsu_ready), 32'd1);
    for (int i = 0; i < NumRegs; i++) begin
      check_reads(reg_addr_t'(i), reg_addr_t'(NumRegs - 1 - i), reg_addr_t'((i + 1) % NumRegs));
    end
    // Both lanes target x0, the writes go through and vanish
    drive_alu('0, $urandom);
    complete_handshakes(1'b1, 1'b0);
    settle(1);
    check_reads('0, '0, '0);
    drive_lsu('0, $urandom, 2'd0, WORD, 1'b0);
    complete_handshakes(1'b0, 1'b1);
    settle(1);
    check_reads('0, '0, '0);
    end_test("reset_x0");
  endtask

  task automatic test_alu_lane();
    reg_data_t data;
    begin_test();
    for (int i = 1; i < NumRegs; i++) begin
      data = $urandom;
      drive_alu(reg_addr_t'(i), data);
      complete_handshakes(1'b1, 1'b0);
      settle(1);
      model_write(reg_addr_t'(i), data);
      check_reads(reg_addr_t'(i), reg_addr_t'(i), reg_addr_t'(i));
    end
    // Full sweep, each port sees each register
    for (int i = 0; i < NumRegs; i++) begin
      check_reads(reg_addr_t'(i), reg_addr_t'(NumRegs - 1 - i), reg_addr_t'((i + 21) % NumRegs));
    end
    end_test("alu_lane");
  endtask

  task automatic test_load_format();
    reg_data_t raw;
    reg_addr_t addr;
    int        n;
    begin_test();
    n = 0;
    // Pass 0 keeps every sign bit clear, pass 1 sets them all
    for (int pass = 0; pass < 2; pass++) begin
      for (int s = 0; s < 3; s++) begin
        for (int off = 0; off < 4; off++) begin
          for (int sg = 0; sg < 2; sg++) begin
            raw  = (pass == 0) ? ($urandom & 32'h7f7f_7f7f) : ($urandom | 32'h8080_8080);
            addr = reg_addr_t'(1 + (n % (NumRegs - 1)));
            n++;
            drive_lsu(addr, raw, 2'(off), load_size_e'(s), sg[0]);
            complete_handshakes(1'b0, 1'b1);
            settle(1);
            model_write(addr, expect_load(raw, 2'(off), load_size_e'(s), sg[0]));
            check_reads(addr, '0, addr);
          end
        end
      end
    end
    end_test("load_format");
  endtask

  // Same cycle on both lanes, rd_alu and rd_lsu differ
  task automatic concurrent_pair(input reg_addr_t rd_alu, input reg_addr_t rd_lsu);
    reg_data_t data;
    reg_data_t raw;
    data = $urandom;
    raw  = $urandom;
    drive_alu(rd_alu, data);
    drive_lsu(rd_lsu, raw, 2'd2, HALF, 1'b1);
    complete_handshakes(1'b1, 1'b1);
    settle(1);
    model_write(rd_alu, data);
    model_write(rd_lsu, expect_load(raw, 2'd2, HALF, 1'b1));
    check_reads(rd_alu, rd_lsu, '0);
  endtask

  task automatic test_concurrent();
    begin_test();
    concurrent_pair(reg_addr_t'(5), reg_addr_t'(NumRegs - 24));
    concurrent_pair(reg_addr_t'(NumRegs - 29), reg_addr_t'(7));
    end_test("concurrent");
  endtask

  // Load writes first, the younger ALU result lands one cycle later
  // Load value seen after the second edge means the load lane kept its latency
  task automatic conflict_on(input reg_addr_t rd);
    reg_data_t data;
    reg_data_t raw;
    data = $urandom;
    raw  = $urandom;
    drive_alu(rd, data);
    drive_lsu(rd, raw, 2'd0, WORD, 1'b0);
    complete_handshakes(1'b1, 1'b1);
    settle(1);
    model_write(rd, raw);
    check_reads(rd, rd, rd);
    model_write(rd, data);
    check_reads(rd, rd, rd);
  endtask

  task automatic test_conflict();
    begin_test();
    conflict_on(reg_addr_t'(12));
    conflict_on(reg_addr_t'(NumRegs - 14));
    end_test("conflict");
  endtask

  task automatic test_stream();
    reg_addr_t addrs [StreamLen];
    reg_data_t datas [StreamLen];
    int        k;
    int        n;
    int        cycles;
    bit        take;
    begin_test();
    for (int i = 0; i < StreamLen; i++) begin
      addrs[i] = reg_addr_t'((4 * i + 1) % NumRegs);
      datas[i] = $urandom;
    end
    k      = 0;
    n      = 0;
    cycles = 0;
    drive_alu(addrs[0], datas[0]);
    while (k < StreamLen && n < Timeout) begin
      take = alu_ready;
      @(posedge clk);
      @(negedge clk);
      cycles++;
      if (take) begin
        model_write(addrs[k], datas[k]);
        k++;
        n = 0;
        if (k < StreamLen) begin
          drive_alu(addrs[k], datas[k]);
        end else begin
          alu_valid = 1'b0;
        end
      end else begin
        n++;
      end
    end
    if (k < StreamLen) begin
      abort_timeout("alu_ready_o in the ALU stream");
    end else begin
      // One transfer per cycle with nothing on the load lane
      compare_value("ALU stream cycles", reg_data_t'(cycles), reg_data_t'(StreamLen));
      settle(1);
      for (int i = 0; i < StreamLen; i++) begin
        check_reads(addrs[i], addrs[i], addrs[i]);
      end
      end_test("stream");
    end
  endtask

  // --------------------
  // Sequence
  // --------------------

  initial begin
    void'($urandom(70));
    rst_n      = 1'b0;
    alu_valid  = 1'b0;
    alu_waddr  = '0;
    alu_wdata  = '0;
    lsu_valid  = 1'b0;
    lsu_waddr  = '0;
    lsu_rdata  = '0;
    lsu_offset = 2'd0;
    lsu_size   = WORD;
    lsu_signed = 1'b0;
    raddr_a    = '0;
    raddr_b    = '0;
    raddr_c    = '0;
    checks     = 0;
    errors     = 0;
    tests      = 0;
    for (int i = 0; i < NumRegs; i++) begin
      model[i] = '0;
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    test_reset_x0();
    test_alu_lane();
    test_load_format();
    test_concurrent();
    test_conflict();
    test_stream();
    $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* rf_writeback_top.f */
+incdir+rtl
rtl/rf_pkg.sv
rtl/wb_pkg.sv
rtl/wb_skid_buffer.sv
rtl/load_formatter.sv
rtl/register_file.sv
rtl/rf_writeback_top.sv
tests/tb_rf_writeback_top.sv

/* Bender.yml */
package:
  name: rf_writeback

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/rf_pkg.sv
      - rtl/wb_pkg.sv
      - rtl/wb_skid_buffer.sv
      - rtl/load_formatter.sv
      - rtl/register_file.sv
      - rtl/rf_writeback_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/tb_rf_writeback_top.sv
